// ==== src/gat_pkg.sv ====
// Sizes, widths and packed structs of the sparse WH datapath
package gat_pkg;

  // ====================================================================
  // Sizes
  // ====================================================================
  // H columns, also W rows
  localparam int NUM_FEATURE_IN  = 16;
  // W columns, one processing element each
  localparam int NUM_FEATURE_OUT = 4;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int DATA_WIDTH      = 8;
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int FEAT_IDX_WIDTH  = $clog2(NUM_FEATURE_OUT);
  // Flat weight address is row * NUM_FEATURE_OUT + column
  localparam int WEIGHT_ADDR_W   = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT);
  // 16 products of -128 * -128 still fit
  localparam int WH_DATA_WIDTH   = 20;
  localparam int NODE_IDX_WIDTH  = 8;

  // Result queue
  localparam int RES_QUEUE_DEPTH = 2;
  localparam int RES_PTR_WIDTH   = $clog2(RES_QUEUE_DEPTH);
  localparam int RES_CNT_WIDTH   = $clog2(RES_QUEUE_DEPTH + 1);

  // ====================================================================
  // Packed structs
  // ====================================================================
  // One sparse entry of an H row
  typedef struct packed {
    logic [DATA_WIDTH-1:0]    val;
    logic [COL_IDX_WIDTH-1:0] col;
    logic                     last;
  } h_entry_t;

  // Entry value plus its W row, sent to every element
  typedef struct packed {
    logic                                       vld;
    logic [DATA_WIDTH-1:0]                      val;
    logic                                       last;
    logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] wgt;
  } pe_bcast_t;

  // One output row of WH, tagged with its node
  typedef struct packed {
    logic [NODE_IDX_WIDTH-1:0]                     node_idx;
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] feat;
  } wh_result_t;

endpackage

// ==== src/wgt_scheduler.sv ====
// Weight memory, entry handshake and entry broadcast to the elements
`timescale 1ns/1ps

module wgt_scheduler
  import gat_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Weight write port
  input  logic                     wgt_we_i,
  input  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]    wgt_din_i,

  // Sparse entry stream
  input  logic                     in_vld_i,
  input  h_entry_t                 in_data_i,
  output logic                     in_rdy_o,

  // Room for another row in the result queue
  input  logic                     row_credit_i,

  output pe_bcast_t                bcast_o
);

  // ====================================================================
  // W memory, one full row of weights per H column
  // ====================================================================
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] wgt_mem [NUM_FEATURE_IN];

  logic [COL_IDX_WIDTH-1:0]  wr_row;
  logic [FEAT_IDX_WIDTH-1:0] wr_col;

  assign wr_row = wgt_addr_i[WEIGHT_ADDR_W-1:FEAT_IDX_WIDTH];
  assign wr_col = wgt_addr_i[FEAT_IDX_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_mem[wr_row][wr_col] <= wgt_din_i;
    end
  end

  // ====================================================================
  // Entry handshake
  // ====================================================================
  logic accept;

  // Only a row end needs a slot in the result queue
  assign in_rdy_o = !in_data_i.last || row_credit_i;
  assign accept   = in_vld_i && in_rdy_o;

  // ====================================================================
  // Broadcast register
  // ====================================================================
  logic                                       bcast_vld_q;
  logic                                       bcast_last_q;
  logic [DATA_WIDTH-1:0]                      bcast_val_q;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] bcast_wgt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bcast_vld_q  <= 1'b0;
      bcast_last_q <= 1'b0;
    end else begin
      bcast_vld_q  <= accept;
      bcast_last_q <= accept && in_data_i.last;
    end
  end

  // Value and W row are registered together with the valid
  always_ff @(posedge clk) begin
    if (accept) begin
      bcast_val_q <= in_data_i.val;
      bcast_wgt_q <= wgt_mem[in_data_i.col];
    end
  end

  always_comb begin
    bcast_o.vld  = bcast_vld_q;
    bcast_o.val  = bcast_val_q;
    bcast_o.last = bcast_last_q;
    bcast_o.wgt  = bcast_wgt_q;
  end

endmodule

// ==== src/wh_pe.sv ====
// Multiply-accumulate element for one output feature of WH
`timescale 1ns/1ps

module wh_pe
  import gat_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,

  input  pe_bcast_t                       bcast_i,
  input  logic signed [DATA_WIDTH-1:0]    wgt_i,

  output logic signed [WH_DATA_WIDTH-1:0] sum_o
);

  logic signed [2*DATA_WIDTH-1:0]    prod;
  logic signed [WH_DATA_WIDTH-1:0]   prod_ext;
  logic signed [WH_DATA_WIDTH-1:0]   acc_next;
  logic signed [WH_DATA_WIDTH-1:0]   acc_q;
  logic signed [WH_DATA_WIDTH-1:0]   sum_q;

  // ====================================================================
  // Product and running sum
  // ====================================================================
  assign prod     = $signed(bcast_i.val) * wgt_i;
  assign prod_ext = WH_DATA_WIDTH'(prod);
  assign acc_next = acc_q + prod_ext;

  // Row end moves the total out and restarts from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      sum_q <= '0;
    end else if (bcast_i.vld) begin
      if (bcast_i.last) begin
        sum_q <= acc_next;
        acc_q <= '0;
      end else begin
        acc_q <= acc_next;
      end
    end
  end

  assign sum_o = sum_q;

endmodule

// ==== src/wh_collector.sv ====
// Row-end capture of element sums into a two-deep result queue
`timescale 1ns/1ps

module wh_collector
  import gat_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_n,

  input  pe_bcast_t                                     bcast_i,
  input  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] sums_i,

  output logic                                          row_credit_o,

  // Result stream
  output logic                                          res_vld_o,
  output wh_result_t                                    res_data_o,
  input  logic                                          res_rdy_i
);

  logic                      push_q;
  logic                      pop;
  logic [NODE_IDX_WIDTH-1:0] node_idx_q;
  logic [RES_PTR_WIDTH-1:0]  wr_ptr_q;
  logic [RES_PTR_WIDTH-1:0]  rd_ptr_q;
  logic [RES_CNT_WIDTH-1:0]  count_q;
  logic [RES_CNT_WIDTH:0]    rows_held;

  wh_result_t queue_mem [RES_QUEUE_DEPTH];

  // ====================================================================
  // Row end tracking
  // ====================================================================
  // Sums are final one cycle after the last broadcast
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_q <= 1'b0;
    end else begin
      push_q <= bcast_i.vld && bcast_i.last;
    end
  end

  // Stored rows plus rows still on their way in
  assign rows_held = count_q + (bcast_i.vld && bcast_i.last) + push_q;
  assign row_credit_o = rows_held < RES_QUEUE_DEPTH;

  // ====================================================================
  // Result queue
  // ====================================================================
  assign pop = res_vld_o && res_rdy_i;

  always_ff @(posedge clk) begin
    if (push_q) begin
      queue_mem[wr_ptr_q].node_idx <= node_idx_q;
      queue_mem[wr_ptr_q].feat     <= sums_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      node_idx_q <= '0;
    end else begin
      if (push_q) begin
        wr_ptr_q   <= wr_ptr_q + 1'b1;
        node_idx_q <= node_idx_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop in one cycle leave the count unchanged
      if (push_q && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_q) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign res_vld_o  = count_q != '0;
  assign res_data_o = queue_mem[rd_ptr_q];

endmodule

// ==== src/gat_wh_top.sv ====
// Top level of the WH stage with scheduler, element bank and collector
`timescale 1ns/1ps

module gat_wh_top
  import gat_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Weight write port
  input  logic                     wgt_we_i,
  input  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]    wgt_din_i,

  // Sparse entry stream
  input  logic                     in_vld_i,
  input  h_entry_t                 in_data_i,
  output logic                     in_rdy_o,

  // Result stream
  output logic                     res_vld_o,
  output wh_result_t               res_data_o,
  input  logic                     res_rdy_i
);

  pe_bcast_t                                     bcast;
  logic                                          row_credit;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] pe_sum;

  // ====================================================================
  // Scheduler
  // ====================================================================
  wgt_scheduler u_scheduler (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_we_i     (wgt_we_i),
    .wgt_addr_i   (wgt_addr_i),
    .wgt_din_i    (wgt_din_i),
    .in_vld_i     (in_vld_i),
    .in_data_i    (in_data_i),
    .in_rdy_o     (in_rdy_o),
    .row_credit_i (row_credit),
    .bcast_o      (bcast)
  );

  // ====================================================================
  // Element bank, one per output feature
  // ====================================================================
  for (genvar i = 0; i < NUM_FEATURE_OUT; i++) begin : g_pe
    wh_pe u_pe (
      .clk     (clk),
      .rst_n   (rst_n),
      .bcast_i (bcast),
      .wgt_i   (bcast.wgt[i]),
      .sum_o   (pe_sum[i])
    );
  end

  // ====================================================================
  // Collector
  // ====================================================================
  wh_collector u_collector (
    .clk          (clk),
    .rst_n        (rst_n),
    .bcast_i      (bcast),
    .sums_i       (pe_sum),
    .row_credit_o (row_credit),
    .res_vld_o    (res_vld_o),
    .res_data_o   (res_data_o),
    .res_rdy_i    (res_rdy_i)
  );

endmodule

// ==== bench/tb_checks.svh ====
// Error counters and compare tasks for result rows and control bits
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Wrong values seen on DUT outputs
int value_errs = 0;
// Missing or extra results, file problems, timeout
int proto_errs = 0;

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    value_errs++;
    $display("Fail at time %0t: %s expected %b, got %b", $time, name, exp, act);
  end
endtask

task automatic check_result(input string name, input wh_result_t exp, input wh_result_t act);
  int i;
  if (act.node_idx !== exp.node_idx) begin
    value_errs++;
    $display("Fail at time %0t: %s.node_idx expected %0d, got %0d",
             $time, name, exp.node_idx, act.node_idx);
  end
  for (i = 0; i < NUM_FEATURE_OUT; i++) begin
    if (act.feat[i] !== exp.feat[i]) begin
      value_errs++;
      $display("Fail at time %0t: %s.feat[%0d] expected %0d, got %0d",
               $time, name, i, $signed(exp.feat[i]), $signed(act.feat[i]));
    end
  end
endtask

// ======================================================================
// Other failures
// ======================================================================
task automatic report_problem(input string msg);
  proto_errs++;
  $display("Error at time %0t: %s", $time, msg);
endtask

task automatic print_counts();
  $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
endtask

`endif

// ==== bench/tb_gat_wh.sv ====
// Testbench for the WH stage with pattern reader, stimulus, result monitor and watchdog
`timescale 1ns/1ps

module tb_gat_wh
  import gat_pkg::*;
();

  `include "tb_checks.svh"

  localparam int    CLK_PERIOD      = 8;
  localparam int    RESET_CYCLES    = 10;
  localparam int    CYCLES_PER_ITEM = 20;
  localparam int    TAIL_CYCLES     = 20;
  localparam string PATTERN_FILE    = "bench/wh_patterns.txt";

  // One W or E line of the pattern file
  typedef struct packed {
    logic [7:0] kind;
    int         a;
    int         b;
    int         c;
  } cmd_t;

  logic                     clk;
  logic                     rst_n;
  logic                     wgt_we_i;
  logic [WEIGHT_ADDR_W-1:0] wgt_addr_i;
  logic [DATA_WIDTH-1:0]    wgt_din_i;
  logic                     in_vld_i;
  h_entry_t                 in_data_i;
  logic                     in_rdy_o;
  logic                     res_vld_o;
  wh_result_t               res_data_o;
  logic                     res_rdy_i;

  cmd_t       cmd_q[$];
  wh_result_t exp_q[$];
  int         n_entries = 0;
  int         n_results = 0;
  int         rows_sent = 0;
  integer     seed;
  logic       loaded    = 1'b0;
  logic       stall_en  = 1'b0;
  logic       held_vld  = 1'b0;
  wh_result_t held_res;
  logic       row0_sent = 1'b0;
  time        row0_last_t;

  always #(CLK_PERIOD / 2) clk = ~clk;

  gat_wh_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_din_i  (wgt_din_i),
    .in_vld_i   (in_vld_i),
    .in_data_i  (in_data_i),
    .in_rdy_o   (in_rdy_o),
    .res_vld_o  (res_vld_o),
    .res_data_o (res_data_o),
    .res_rdy_i  (res_rdy_i)
  );

  // ======================================================================
  // Pattern file
  // ======================================================================
  task automatic read_patterns();
    int                 fd;
    int                 code;
    byte                kind;
    int                 a, b, c, d, e;
    logic [8*128-1:0]   rest;
    wh_result_t         res;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      report_problem("the pattern file could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        break;
      end
      case (kind)
        "#": code = $fgets(rest, fd);
        "W": begin
          code = $fscanf(fd, "%d %d", a, b);
          cmd_q.push_back('{kind, a, b, 0});
        end
        "E": begin
          code = $fscanf(fd, "%d %d %d", a, b, c);
          cmd_q.push_back('{kind, a, b, c});
          n_entries++;
        end
        "R": begin
          code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
          res.node_idx = NODE_IDX_WIDTH'(a);
          res.feat[0]  = WH_DATA_WIDTH'(b);
          res.feat[1]  = WH_DATA_WIDTH'(c);
          res.feat[2]  = WH_DATA_WIDTH'(d);
          res.feat[3]  = WH_DATA_WIDTH'(e);
          exp_q.push_back(res);
          n_results++;
        end
        default: report_problem("the pattern file holds a line of unknown kind");
      endcase
    end
    $fclose(fd);
  endtask

  // ======================================================================
  // Stimulus
  // ======================================================================
  task automatic drive_weight(input int addr, input int wgt);
    @(negedge clk);
    in_vld_i   = 1'b0;
    wgt_we_i   = 1'b1;
    wgt_addr_i = WEIGHT_ADDR_W'(addr);
    wgt_din_i  = DATA_WIDTH'(wgt);
  endtask

  task automatic drive_entry(input int val, input int col, input int last);
    @(negedge clk);
    wgt_we_i       = 1'b0;
    in_vld_i       = 1'b1;
    in_data_i.val  = DATA_WIDTH'(val);
    in_data_i.col  = COL_IDX_WIDTH'(col);
    in_data_i.last = (last != 0);
    @(posedge clk);
    while (!in_rdy_o) @(posedge clk);
    if (last != 0) begin
      // Latency reference for the first row
      if (rows_sent == 0) begin
        row0_last_t = $time;
        row0_sent   = 1'b1;
      end
      rows_sent++;
    end
  endtask

  task automatic run_commands();
    cmd_t cmd;
    while (cmd_q.size() != 0) begin
      cmd = cmd_q.pop_front();
      if (cmd.kind == "W") begin
        drive_weight(cmd.a, cmd.b);
      end else begin
        drive_entry(cmd.a, cmd.b, cmd.c);
      end
    end
    @(negedge clk);
    in_vld_i = 1'b0;
    wgt_we_i = 1'b0;
  endtask

  // Random stalls start once the first result has left
  always @(negedge clk) begin
    if (stall_en) begin
      res_rdy_i = ($random(seed) & 1) != 0;
    end
  end

  // ======================================================================
  // Result monitor
  // ======================================================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (held_vld) begin
        check_flag("res_vld_o", 1'b1, res_vld_o);
        check_result("res_data_o", held_res, res_data_o);
      end
      if (row0_sent && $time == row0_last_t + 2 * CLK_PERIOD) begin
        check_flag("res_vld_o", 1'b0, res_vld_o);
      end
      if (row0_sent && $time == row0_last_t + 3 * CLK_PERIOD) begin
        check_flag("res_vld_o", 1'b1, res_vld_o);
      end
      if (res_vld_o && res_rdy_i) begin
        if (exp_q.size() == 0) begin
          report_problem("a result arrived after all expected rows were seen");
        end else begin
          check_result("res_data_o", exp_q.pop_front(), res_data_o);
        end
        stall_en = 1'b1;
      end
      held_vld = res_vld_o && !res_rdy_i;
      held_res = res_data_o;
    end
  end

  // ======================================================================
  // Watchdog
  // ======================================================================
  initial begin
    int limit_cycles;
    wait (loaded);
    limit_cycles = (n_entries + n_results) * CYCLES_PER_ITEM + RESET_CYCLES + TAIL_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    report_problem($sformatf("timeout with %0d expected results still missing",
                             exp_q.size()));
    print_counts();
    $display("Done: errors found");
    $finish;
  end

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_din_i  = '0;
    in_vld_i   = 1'b0;
    in_data_i  = '0;
    res_rdy_i  = 1'b1;
    seed       = 5;
    read_patterns();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // A waiting row end makes in_rdy_o follow the row credit
    in_data_i.last = 1'b1;
    @(posedge clk);
    check_flag("res_vld_o", 1'b0, res_vld_o);
    check_flag("in_rdy_o", 1'b1, in_rdy_o);
    run_commands();
    while (exp_q.size() != 0) @(posedge clk);
    // Room for any extra result to show up
    repeat (TAIL_CYCLES) @(posedge clk);
    print_counts();
    if (value_errs + proto_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+bench
src/gat_pkg.sv
src/wgt_scheduler.sv
src/wh_pe.sv
src/wh_collector.sv
src/gat_wh_top.sv
bench/tb_gat_wh.sv

// ==== Bender.yml ====
package:
  name: gat_wh

sources:
  - files:
      - src/gat_pkg.sv
      - src/wgt_scheduler.sv
      - src/wh_pe.sv
      - src/wh_collector.sv
      - src/gat_wh_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_gat_wh.sv

// ==== bench/wh_patterns.txt ====
# W <addr> <weight> with addr = row * 4 + column, E <value> <column> <last>
# R <node> <feat0> <feat1> <feat2> <feat3>
# Numbers are decimal
W 0 1
W 1 2
W 2 3
W 3 4
W 4 -1
W 5 5
W 6 0
W 7 10
W 60 127
W 61 -128
W 62 -128
W 63 127
E 2 0 0
E 3 1 1
R 0 -1 19 6 38
E -4 1 1
R 1 4 -20 0 -40
E 7 0 1
R 2 7 14 21 28
E -128 15 0
E -128 15 0
E -128 15 0
E 127 15 0
E -128 15 1
R 3 -48895 49280 49280 -48895
E 127 15 0
E -128 0 0
E 127 1 1
R 4 15874 -15877 -16640 16887
E 0 1 1
R 5 0 0 0 0
# Reload of W row 0
W 0 -2
W 1 6
W 2 -7
W 3 100
E 3 0 0
E -1 1 1
R 6 -5 13 -21 290
E -128 0 1
R 7 256 -768 896 -12800
E 10 0 0
E 2 15 1
R 8 234 -196 -326 1254
